/* pool_assert.sv */
// busy/done protocol assertions
// bound into the pool controller
module pool_assert import pool_pkg::*; (
    input logic       clk,
    input logic       rst,
    input logic [2:0] op,
    input logic       xfer_start,
    input logic       find_start,
    input logic       bsy,
    input logic       done
);

    a_done_pulse: assert property (@(posedge clk) disable iff (rst) done |=> !done)
        else $error("done held for more than one cycle");

    // bsy falls in the done cycle
    a_done_end: assert property (@(posedge clk) disable iff (rst) done |-> !bsy && $past(bsy))
        else $error("done without a preceding busy period");

    a_accept: assert property (@(posedge clk) disable iff (rst) (!bsy && op != NOP) |=> bsy)
        else $error("command not accepted while idle");

    a_hold: assert property (@(posedge clk) disable iff (rst) bsy |=> (bsy || done))
        else $error("bsy dropped before done");

    a_ignore: assert property (@(posedge clk) disable iff (rst)
                               bsy |=> !(xfer_start || find_start))
        else $error("engine started by an op issued while busy");

endmodule

bind pool_ctrl pool_assert u_assert (
    .clk, .rst, .op, .xfer_start, .find_start, .bsy, .done
);

/* pool_check.sv */
// pool result checker
// keeps a byte model of accepted writes and compares vo and ao at each done
`include "pool_settings.svh"

module pool_check import pool_pkg::*; (
    input  logic                 clk,
    input  logic                 rst,
    input  logic [2:0]           op,
    input  logic [`POOL_ASZ-1:0] ai,
    input  logic [`POOL_DSZ-1:0] vi,
    input  logic [`POOL_ASZ-1:0] exp_ao,
    input  logic [`POOL_DSZ-1:0] vo,
    input  logic [`POOL_ASZ-1:0] ao,
    input  logic                 bsy,
    input  logic                 done,
    output int                   checks,
    output int                   mismatches,
    output int                   proto_errs
);

    logic [7:0]           model [`POOL_DEPTH];
    pool_op_e             cur_op;
    logic [`POOL_ASZ-1:0] cur_ai;
    logic [`POOL_ASZ-1:0] cur_ao;
    logic                 pend;
    logic                 first;          // first edge out of reset

    function automatic int op_bytes(input pool_op_e o);
        case (o)
            R1, W1:  return 1;
            R2, W2:  return 2;
            default: return 4;
        endcase
    endfunction

    // big-endian with zero extension
    function automatic logic [`POOL_DSZ-1:0] model_read(input logic [`POOL_ASZ-1:0] a,
                                                       input int n);
        logic [`POOL_DSZ-1:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[`POOL_DSZ-9:0], model[a + `POOL_ASZ'(i)]};
        end
        return v;
    endfunction

    task automatic compare(input string name, input logic [31:0] exp, input logic [31:0] act);
        checks++;
        if (act !== exp) begin
            mismatches++;
            $display("Fail at %0t: %s expected %h, got %h", $time, name, exp, act);
        end
    endtask

    always @(posedge clk) begin
        if (rst) begin
            pend       = 1'b0;
            first      = 1'b1;
            checks     = 0;
            mismatches = 0;
            proto_errs = 0;
        end else begin
            if (first) begin
                compare("bsy", 32'h0, 32'(bsy));
                compare("done", 32'h0, 32'(done));
                compare("vo", 32'h0, vo);
                compare("ao", 32'h0, 32'(ao));
                first = 1'b0;
            end
            if (done) begin
                if (!pend) begin
                    proto_errs++;
                    $display("%0t: done pulse with no command pending", $time);
                end else if (cur_op == FIND) begin
                    compare("ao", 32'(cur_ao), 32'(ao));
                end else if (!cur_op[2]) begin
                    compare("vo", model_read(cur_ai, op_bytes(cur_op)), vo);
                end
                pend = 1'b0;
            end
            if (!bsy && op != NOP) begin   // accepted at this edge
                if (pend) begin
                    proto_errs++;
                    $display("%0t: command accepted before the last one finished", $time);
                end
                pend   = 1'b1;
                cur_op = pool_op_e'(op);
                cur_ai = ai;
                cur_ao = exp_ao;
                if (op[2] && op[1:0] != 2'b00) begin
                    for (int i = 0; i < op_bytes(cur_op); i++) begin
                        model[ai + `POOL_ASZ'(i)] = vi[8 * (op_bytes(cur_op) - 1 - i) +: 8];
                    end
                end
            end
        end
    end

endmodule

/* pool_ctrl.sv */
// pool command controller
// decodes opcodes, runs bsy/done and hands the RAM port to the active engine
`include "pool_settings.svh"

module pool_ctrl import pool_pkg::*; (
    input  logic                 clk,
    input  logic                 rst,
    input  logic [2:0]           op,
    input  logic [`POOL_ASZ-1:0] ai,
    input  logic [`POOL_DSZ-1:0] vi,
    output logic                 xfer_start,
    output logic [2:0]           xfer_len,
    output logic                 xfer_wr,
    output logic                 find_start,
    output logic [`POOL_ASZ-1:0] cmd_ai,
    output logic [`POOL_DSZ-1:0] cmd_vi,
    input  logic [`POOL_ASZ-1:0] xfer_req_addr,
    input  logic                 xfer_req_we,
    input  logic [7:0]           xfer_req_wdata,
    input  logic [`POOL_ASZ-1:0] find_req_addr,
    input  logic                 xfer_done,
    input  logic [`POOL_DSZ-1:0] rd_data,
    input  logic                 find_done,
    input  logic [`POOL_ASZ-1:0] find_addr,
    output logic [`POOL_ASZ-1:0] mem_addr,
    output logic                 mem_we,
    output logic [7:0]           mem_wdata,
    output logic [`POOL_DSZ-1:0] vo,
    output logic [`POOL_ASZ-1:0] ao,
    output logic                 bsy,
    output logic                 done
);

    ctrl_st_e st;
    pool_op_e op_e;
    logic     accept;

    assign op_e   = pool_op_e'(op);
    assign accept = (st == CS_IDLE) && (op_e != NOP);   // op ignored while busy

    always_ff @(posedge clk) begin
        if (rst) begin
            st         <= CS_IDLE;
            xfer_start <= 1'b0;
            xfer_len   <= 3'd0;
            xfer_wr    <= 1'b0;
            find_start <= 1'b0;
            vo         <= '0;
            ao         <= '0;
            bsy        <= 1'b0;
            done       <= 1'b0;
        end else begin
            xfer_start <= 1'b0;
            find_start <= 1'b0;
            done       <= 1'b0;
            case (st)
                CS_IDLE: begin
                    if (accept) begin
                        bsy <= 1'b1;
                        if (op_e == FIND) begin
                            find_start <= 1'b1;
                            st         <= CS_FIND;
                        end else begin
                            xfer_start <= 1'b1;
                            xfer_wr    <= op[2];
                            case (op[1:0])
                                2'b01:   xfer_len <= 3'd1;
                                2'b10:   xfer_len <= 3'd2;
                                default: xfer_len <= 3'd4;
                            endcase
                            st <= CS_XFER;
                        end
                    end
                end
                CS_XFER: begin
                    if (xfer_done) begin
                        done <= 1'b1;
                        bsy  <= 1'b0;
                        st   <= CS_IDLE;
                        if (!xfer_wr) begin
                            vo <= rd_data;
                        end
                    end
                end
                default: begin
                    if (find_done) begin
                        done <= 1'b1;
                        bsy  <= 1'b0;
                        ao   <= find_addr;
                        st   <= CS_IDLE;
                    end
                end
            endcase
        end
    end

    // command operands, held for the engines
    always_ff @(posedge clk) begin
        if (accept) begin
            cmd_ai <= ai;
            cmd_vi <= vi;
        end
    end

    assign mem_addr  = (st == CS_FIND) ? find_req_addr : xfer_req_addr;
    assign mem_we    = (st == CS_XFER) && xfer_req_we;
    assign mem_wdata = xfer_req_wdata;       // walker only reads

endmodule

/* pool_find.sv */
// dictionary walker
// follows the link chain from the latest entry and compares each
// null-terminated name against the key string, byte by byte
`include "pool_settings.svh"

module pool_find import pool_pkg::*; (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 start,
    input  logic [`POOL_ASZ-1:0] key,      // key string address
    input  logic [`POOL_ASZ-1:0] latest,   // newest entry, 0 for empty
    output logic [`POOL_ASZ-1:0] req_addr,
    input  logic [7:0]           ram_rdata,
    output logic [`POOL_ASZ-1:0] found,    // 0 when not found
    output logic                 done
);

    find_st_e               st, nxt;
    logic [`POOL_ASZ-1:0]   ent;           // current entry
    logic [`POOL_ASZ-1:0]   a0;            // key pointer
    logic [`POOL_ASZ-1:0]   a1;            // name pointer
    logic [15:0]            link;
    logic                   lo_pend;       // link low byte due this cycle
    logic [7:0]             kb;            // key byte under compare
    logic                   last_link;

    assign last_link = (link == 16'h0);

    always_comb begin
        nxt = st;
        case (st)
            FS_IDLE: begin
                if (start) begin
                    nxt = (latest == '0) ? FS_MISS : FS_LINK_HI;
                end
            end
            FS_LINK_HI: nxt = FS_LINK_LO;
            FS_LINK_LO: nxt = FS_KEY_RD;
            FS_KEY_RD:  nxt = FS_NAME_RD;
            FS_NAME_RD: nxt = FS_CMP;
            FS_CMP: begin
                if (kb != ram_rdata) begin
                    nxt = last_link ? FS_MISS : FS_LINK_HI;
                end else if (kb == 8'h0) begin
                    nxt = FS_HIT;          // both terminators reached
                end else begin
                    nxt = FS_KEY_RD;
                end
            end
            default: nxt = FS_IDLE;        // HIT and MISS last one cycle
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            st      <= FS_IDLE;
            found   <= '0;
            lo_pend <= 1'b0;
        end else begin
            st      <= nxt;
            lo_pend <= (st == FS_LINK_LO);
            if (st == FS_IDLE && start) begin
                found <= '0;
            end else if (st == FS_CMP && nxt == FS_HIT) begin
                found <= ent;
            end
        end
    end

    always_ff @(posedge clk) begin
        case (st)
            FS_IDLE: begin
                ent <= latest;
            end
            FS_LINK_LO: begin
                link[15:8] <= ram_rdata;
                a0         <= key;
                a1         <= ent + `POOL_ASZ'(2);  // name follows link
            end
            FS_KEY_RD: begin
                if (lo_pend) begin
                    link[7:0] <= ram_rdata;
                end
            end
            FS_NAME_RD: begin
                kb <= ram_rdata;
            end
            FS_CMP: begin
                if (kb != ram_rdata) begin
                    ent <= `POOL_ASZ'(link);
                end else begin
                    a0 <= a0 + 1'b1;
                    a1 <= a1 + 1'b1;
                end
            end
            default: ;
        endcase
    end

    always_comb begin
        case (st)
            FS_LINK_LO: req_addr = ent + `POOL_ASZ'(1);
            FS_KEY_RD:  req_addr = a0;
            FS_NAME_RD: req_addr = a1;
            default:    req_addr = ent;    // link high byte
        endcase
    end

    assign done = (st == FS_HIT) || (st == FS_MISS);

endmodule

/* pool_pkg.sv */
// memory pool types
// opcode and FSM state encodings shared by the pool blocks
package pool_pkg;

    // bit 2 with a nonzero low part means write
    typedef enum logic [2:0] {
        NOP  = 3'd0,
        R1   = 3'd1,
        R2   = 3'd2,
        R4   = 3'd3,
        FIND = 3'd4,
        W1   = 3'd5,
        W2   = 3'd6,
        W4   = 3'd7
    } pool_op_e;

    typedef enum logic [2:0] {
        FS_IDLE, FS_LINK_HI, FS_LINK_LO, FS_KEY_RD,
        FS_NAME_RD, FS_CMP, FS_HIT, FS_MISS
    } find_st_e;

    typedef enum logic [1:0] {XS_IDLE, XS_RUN, XS_LAST} xfer_st_e;

    typedef enum logic [1:0] {CS_IDLE, CS_XFER, CS_FIND} ctrl_st_e;

endpackage

/* pool_ram.sv */
// pool byte RAM
// single port, synchronous write, registered read every cycle
`include "pool_settings.svh"

module pool_ram (
    input  logic                 clk,
    input  logic [`POOL_ASZ-1:0] addr,
    input  logic                 we,
    input  logic [7:0]           wdata,
    output logic [7:0]           rdata
);

    logic [7:0] mem [`POOL_DEPTH];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr] <= wdata;
        end
        rdata <= mem[addr];                 // old data on a write cycle
    end

endmodule

/* pool_settings.svh */
// memory pool sizing
// address width, command data width and RAM depth in bytes
`ifndef POOL_SETTINGS_SVH
`define POOL_SETTINGS_SVH

// 17 address bits give a 128K byte space
`define POOL_ASZ 17

// command data bus, one 32-bit word
`define POOL_DSZ 32

// one byte per address
`define POOL_DEPTH (1 << `POOL_ASZ)

`endif

/* pool_top.sv */
// memory pool top
// controller, transfer engine, dictionary walker and byte RAM
`include "pool_settings.svh"

module pool_top (
    input  logic                 clk,
    input  logic                 rst,
    input  logic [2:0]           op,
    input  logic [`POOL_ASZ-1:0] ai,
    input  logic [`POOL_DSZ-1:0] vi,     // data, or latest entry for FIND
    output logic [`POOL_DSZ-1:0] vo,
    output logic [`POOL_ASZ-1:0] ao,
    output logic                 bsy,
    output logic                 done
);

    logic                 xfer_start;
    logic [2:0]           xfer_len;
    logic                 xfer_wr;
    logic                 find_start;
    logic [`POOL_ASZ-1:0] cmd_ai;
    logic [`POOL_DSZ-1:0] cmd_vi;
    logic [`POOL_ASZ-1:0] xfer_req_addr;
    logic                 xfer_req_we;
    logic [7:0]           xfer_req_wdata;
    logic [`POOL_ASZ-1:0] find_req_addr;
    logic                 xfer_done;
    logic [`POOL_DSZ-1:0] rd_data;
    logic                 find_done;
    logic [`POOL_ASZ-1:0] find_addr;
    logic [`POOL_ASZ-1:0] mem_addr;
    logic                 mem_we;
    logic [7:0]           mem_wdata;
    logic [7:0]           ram_rdata;

    pool_ctrl u_ctrl (
        .clk, .rst, .op, .ai, .vi,
        .xfer_start, .xfer_len, .xfer_wr, .find_start,
        .cmd_ai, .cmd_vi,
        .xfer_req_addr, .xfer_req_we, .xfer_req_wdata, .find_req_addr,
        .xfer_done, .rd_data, .find_done, .find_addr,
        .mem_addr, .mem_we, .mem_wdata,
        .vo, .ao, .bsy, .done
    );

    pool_xfer u_xfer (
        .clk, .rst,
        .start      (xfer_start),
        .len        (xfer_len),
        .wr         (xfer_wr),
        .base       (cmd_ai),
        .wdata_word (cmd_vi),
        .req_addr   (xfer_req_addr),
        .req_we     (xfer_req_we),
        .req_wdata  (xfer_req_wdata),
        .ram_rdata,
        .rd_data,
        .done       (xfer_done)
    );

    pool_find u_find (
        .clk, .rst,
        .start      (find_start),
        .key        (cmd_ai),
        .latest     (cmd_vi[`POOL_ASZ-1:0]),
        .req_addr   (find_req_addr),
        .ram_rdata,
        .found      (find_addr),
        .done       (find_done)
    );

    pool_ram u_ram (
        .clk,
        .addr  (mem_addr),
        .we    (mem_we),
        .wdata (mem_wdata),
        .rdata (ram_rdata)
    );

endmodule

/* pool_xfer.sv */
// byte-serial transfer engine
// issues 1, 2 or 4 consecutive byte accesses, big-endian order
`include "pool_settings.svh"

module pool_xfer import pool_pkg::*; (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 start,
    input  logic [2:0]           len,          // 1, 2 or 4 bytes
    input  logic                 wr,
    input  logic [`POOL_ASZ-1:0] base,
    input  logic [`POOL_DSZ-1:0] wdata_word,
    output logic [`POOL_ASZ-1:0] req_addr,
    output logic                 req_we,
    output logic [7:0]           req_wdata,
    input  logic [7:0]           ram_rdata,
    output logic [`POOL_DSZ-1:0] rd_data,
    output logic                 done
);

    xfer_st_e               st;
    logic [2:0]             cnt;                // bytes left after this one
    logic                   wr_r;
    logic [`POOL_DSZ-1:0]   sreg;               // write bytes, next one on top
    logic [`POOL_DSZ-9:0]   acc;                // bytes already read back
    logic                   rv;                 // ram_rdata holds one of ours
    logic                   rlast;              // ... and it is the last one

    always_ff @(posedge clk) begin
        if (rst) begin
            st    <= XS_IDLE;
            rv    <= 1'b0;
            rlast <= 1'b0;
        end else begin
            rv    <= (st != XS_IDLE) && !wr_r;
            rlast <= (st == XS_LAST) && !wr_r;
            case (st)
                XS_IDLE: begin
                    if (start) begin
                        st <= (len == 3'd1) ? XS_LAST : XS_RUN;
                    end
                end
                XS_RUN: begin
                    if (cnt == 3'd1) begin
                        st <= XS_LAST;
                    end
                end
                default: st <= XS_IDLE;         // LAST is always one cycle
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (st == XS_IDLE && start) begin
            req_addr <= base;
            cnt      <= len - 3'd1;
            wr_r     <= wr;
            acc      <= '0;                     // short reads zero-extend
            case (len)
                3'd1:    sreg <= wdata_word << (`POOL_DSZ - 8);
                3'd2:    sreg <= wdata_word << (`POOL_DSZ - 16);
                default: sreg <= wdata_word;
            endcase
        end else if (st != XS_IDLE) begin
            req_addr <= req_addr + 1'b1;
            cnt      <= cnt - 3'd1;
            sreg     <= sreg << 8;
        end
        if (rv) begin
            acc <= {acc[`POOL_DSZ-17:0], ram_rdata};
        end
    end

    assign req_we    = (st != XS_IDLE) && wr_r;
    assign req_wdata = sreg[`POOL_DSZ-1 -: 8];  // msb first

    // last byte is still on the RAM output, merge it in directly
    assign rd_data = {acc, ram_rdata};

    assign done = ((st == XS_LAST) && wr_r) || rlast;

endmodule

/* run_sim.sh */
#!/usr/bin/env bash
# build the pool testbench with Verilator, run it, and judge the log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal -f sim.f --top-module tb_pool -o tb_pool \
    && { ./obj_dir/tb_pool > sim.log 2>&1; cat sim.log; } \
    || { echo "build failed"; exit 1; }
grep -q "All tests passed!" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

/* sim.f */
+incdir+.
pool_pkg.sv
pool_ram.sv
pool_xfer.sv
pool_find.sv
pool_ctrl.sv
pool_top.sv
pool_assert.sv
pool_check.sv
tb_pool.sv

/* tb_pool.sv */
// memory pool testbench
// applies a command table to pool_top while pool_check compares the results
`include "pool_settings.svh"

module tb_pool import pool_pkg::*; ();

    typedef struct packed {
        pool_op_e             op;
        logic                 rnd;      // write data from the LFSR
        logic [`POOL_ASZ-1:0] ai;
        logic [`POOL_DSZ-1:0] vi;
        logic [`POOL_ASZ-1:0] ao;       // expected ao for FIND
    } step_t;

    localparam int N_STEPS = 28;

    // dictionary entries DUP at 0x200, SWAP at 0x208 and DROP at 0x214 (latest)
    step_t steps [N_STEPS] = '{
        '{NOP,  1'b0, 17'h00000, 32'h0000_0000, 17'h0},
        '{W4,   1'b1, 17'h00100, 32'h0000_0000, 17'h0},
        '{R4,   1'b0, 17'h00100, 32'h0000_0000, 17'h0},
        '{R2,   1'b0, 17'h00100, 32'h0000_0000, 17'h0},
        '{R1,   1'b0, 17'h00100, 32'h0000_0000, 17'h0},
        '{R1,   1'b0, 17'h00101, 32'h0000_0000, 17'h0},
        '{R1,   1'b0, 17'h00102, 32'h0000_0000, 17'h0},
        '{R1,   1'b0, 17'h00103, 32'h0000_0000, 17'h0},
        '{W2,   1'b1, 17'h1fffe, 32'h0000_0000, 17'h0},
        '{R2,   1'b0, 17'h1fffe, 32'h0000_0000, 17'h0},
        '{R1,   1'b0, 17'h1ffff, 32'h0000_0000, 17'h0},
        '{W1,   1'b1, 17'h00150, 32'h0000_0000, 17'h0},
        '{R1,   1'b0, 17'h00150, 32'h0000_0000, 17'h0},
        '{W4,   1'b0, 17'h00200, 32'h0000_4455, 17'h0},
        '{W2,   1'b0, 17'h00204, 32'h0000_5000, 17'h0},
        '{W4,   1'b0, 17'h00208, 32'h0200_5357, 17'h0},
        '{W4,   1'b0, 17'h0020c, 32'h4150_0000, 17'h0},
        '{W4,   1'b0, 17'h00214, 32'h0208_4452, 17'h0},
        '{W4,   1'b0, 17'h00218, 32'h4f50_0000, 17'h0},
        '{W4,   1'b0, 17'h00300, 32'h4455_5000, 17'h0},      // key DUP
        '{W4,   1'b0, 17'h00304, 32'h4455_0000, 17'h0},      // key DU
        '{FIND, 1'b0, 17'h00300, 32'h0000_0214, 17'h00200},
        '{FIND, 1'b0, 17'h00300, 32'h0000_0000, 17'h0},      // empty dictionary
        '{FIND, 1'b0, 17'h0020a, 32'h0000_0214, 17'h00208},
        '{FIND, 1'b0, 17'h00216, 32'h0000_0214, 17'h00214},
        '{FIND, 1'b0, 17'h00304, 32'h0000_0214, 17'h0},      // prefix only
        '{FIND, 1'b0, 17'h00306, 32'h0000_0214, 17'h0},      // empty key
        '{R4,   1'b0, 17'h00100, 32'h0000_0000, 17'h0}
    };

    logic                 clk = 1'b0;
    logic                 rst;
    logic [2:0]           op;
    logic [`POOL_ASZ-1:0] ai;
    logic [`POOL_DSZ-1:0] vi;
    logic [`POOL_ASZ-1:0] exp_ao;
    logic [`POOL_DSZ-1:0] vo;
    logic [`POOL_ASZ-1:0] ao;
    logic                 bsy;
    logic                 done;
    logic [31:0]          lfsr;
    int                   checks;
    int                   mismatches;
    int                   proto_errs;

    always #50 clk = ~clk;

    pool_top u_dut (.clk, .rst, .op, .ai, .vi, .vo, .ao, .bsy, .done);

    pool_check u_check (
        .clk, .rst, .op, .ai, .vi, .exp_ao, .vo, .ao, .bsy, .done,
        .checks, .mismatches, .proto_errs
    );

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    function automatic logic [`POOL_DSZ-1:0] take_bits(input int n);
        logic [`POOL_DSZ-1:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            v = {v[`POOL_DSZ-2:0], lfsr[0]};
        end
        return v;
    endfunction

    // called and returns 5 units after a rising edge
    task automatic apply_step(input step_t s);
        op     = s.op;
        ai     = s.ai;
        exp_ao = s.ao;
        vi     = s.rnd ? take_bits((s.op == W4) ? 32 : 8 * s.op[1:0]) : s.vi;
        @(posedge clk);
        #5;
        if (s.op == NOP) begin
            repeat (4) @(posedge clk);    // a stray done shows up in the checker
            #5;
        end else begin
            op = W4;                       // lands while busy and must not write
            ai = 17'h00100;
            vi = 32'hdead_beef;
            @(posedge clk);
            #5;
            op = NOP;
            while (!done) begin
                @(posedge clk);
                #5;
            end
        end
    endtask

    initial begin
        rst    = 1'b1;
        op     = NOP;
        ai     = '0;
        vi     = '0;
        exp_ao = '0;
        lfsr   = 32'h395b_159e;
        repeat (4) @(posedge clk);
        #5;
        rst = 1'b0;
        for (int i = 0; i < N_STEPS; i++) begin
            apply_step(steps[i]);
        end
        repeat (2) @(posedge clk);
        $display("checks %0d, value errors %0d, protocol errors %0d",
                 checks, mismatches, proto_errs);
        if (checks > 0 && mismatches == 0 && proto_errs == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

    // watchdog allows 200 cycles per table entry
    initial begin
        #(N_STEPS * 200 * 100);
        $display("timeout: the command table did not complete in time");
        $display("Test failures found");
        $finish;
    end

endmodule
